// File: hw/mem_subsys_consts.svh
`ifndef MEM_SUBSYS_CONSTS_SVH
`define MEM_SUBSYS_CONSTS_SVH

// ram depth in 32-bit words, 1 KiB
`define MEM_WORDS 256

// word address into the ram
`define MEM_AW ($clog2(`MEM_WORDS))

// byte address as seen by the request ports
`define BYTE_AW (`MEM_AW + 2)

// bus data width
`define DATA_W 32

`endif

// File: hw/mem_subsys_pkg.sv
package mem_subsys_pkg;

    // load/store opcodes
    // loads first, then stores
    typedef enum logic [2:0]
    {
        LSU_LB  = 3'd0,
        LSU_LH  = 3'd1,
        LSU_LW  = 3'd2,
        LSU_LBU = 3'd3,
        LSU_LHU = 3'd4,
        LSU_SB  = 3'd5,
        LSU_SH  = 3'd6,
        LSU_SW  = 3'd7
    } lsu_op_e;

    // request port state machine
    // wait_grant is the setup cycle before the bus request goes out
    typedef enum logic [1:0]
    {
        PORT_IDLE       = 2'd0,
        PORT_WAIT_GRANT = 2'd1,
        PORT_WAIT_ACK   = 2'd2
    } port_state_e;

endpackage

// File: hw/main_memory.sv
`include "mem_subsys_consts.svh"

module main_memory
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    // wishbone slave side
    input  logic                  i_wb_cyc,
    input  logic                  i_wb_stb,
    input  logic                  i_wb_we,
    input  logic [`MEM_AW-1:0]    i_wb_addr,
    input  logic [`DATA_W-1:0]    i_wb_data,
    input  logic [`DATA_W/8-1:0]  i_wb_sel,
    output logic                  o_wb_ack,
    output logic                  o_wb_stall,
    output logic [`DATA_W-1:0]    o_wb_data
);

    // combined instruction and data storage
    logic [`DATA_W-1:0] mem_q [`MEM_WORDS];

    // strobe taken this cycle
    logic               accept;

    // the ack cycle still sees stb from the master
    // and is not taken as a new request
    assign accept = i_wb_cyc && i_wb_stb && !o_wb_ack;

    // single-cycle slave that never stalls
    assign o_wb_stall = 1'b0;

    // byte-lane writes under sel
    always_ff @(posedge i_clk)
    begin
        if (accept && i_wb_we)
        begin
            for (int lane = 0; lane < `DATA_W/8; lane++)
            begin
                if (i_wb_sel[lane])
                begin
                    mem_q[i_wb_addr][lane*8 +: 8] <= i_wb_data[lane*8 +: 8];
                end
            end
        end
    end

    // registered read valid together with ack
    always_ff @(posedge i_clk)
    begin
        if (accept && !i_wb_we)
        begin
            o_wb_data <= mem_q[i_wb_addr];
        end
    end

    // one ack per accepted strobe
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_wb_ack <= 1'b0;
        end
        else
        begin
            o_wb_ack <= accept;
        end
    end

    // master keeps cyc and stb up until the ack comes back
    property p_ack_with_stb;
        @(posedge i_clk) disable iff (!i_rst_n)
        o_wb_ack |-> (i_wb_cyc && i_wb_stb);
    endproperty

    a_ack_with_stb: assert property (p_ack_with_stb)
        else $error("main_memory: ack without a held strobe");

endmodule

// File: hw/wb_arbiter.sv
`include "mem_subsys_consts.svh"

module wb_arbiter
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    // fetch master
    input  logic                  i_f_cyc,
    input  logic                  i_f_stb,
    input  logic                  i_f_we,
    input  logic [`MEM_AW-1:0]    i_f_addr,
    input  logic [`DATA_W-1:0]    i_f_data,
    input  logic [`DATA_W/8-1:0]  i_f_sel,
    // data master
    input  logic                  i_d_cyc,
    input  logic                  i_d_stb,
    input  logic                  i_d_we,
    input  logic [`MEM_AW-1:0]    i_d_addr,
    input  logic [`DATA_W-1:0]    i_d_data,
    input  logic [`DATA_W/8-1:0]  i_d_sel,
    // slave response
    input  logic                  i_m_ack,
    input  logic [`DATA_W-1:0]    i_m_data,
    output logic                  o_f_ack,
    output logic                  o_d_ack,
    output logic [`DATA_W-1:0]    o_rdata,
    // towards the slave
    output logic                  o_m_cyc,
    output logic                  o_m_stb,
    output logic                  o_m_we,
    output logic [`MEM_AW-1:0]    o_m_addr,
    output logic [`DATA_W-1:0]    o_m_data,
    output logic [`DATA_W/8-1:0]  o_m_sel
);

    // owner flag, 1 = data master
    logic owner_q;
    // a bus cycle is in flight
    logic busy_q;
    // master currently forwarded
    logic grant_d;

    // locked while busy, otherwise data first
    always_comb
    begin
        if (busy_q)
            grant_d = owner_q;
        else if (i_d_cyc)
            grant_d = 1'b1;
        else if (i_f_cyc)
            grant_d = 1'b0;
        else
            grant_d = owner_q;
    end

    // mux the granted master onto the slave
    assign o_m_cyc  = grant_d ? i_d_cyc  : i_f_cyc;
    assign o_m_stb  = grant_d ? i_d_stb  : i_f_stb;
    assign o_m_we   = grant_d ? i_d_we   : i_f_we;
    assign o_m_addr = grant_d ? i_d_addr : i_f_addr;
    assign o_m_data = grant_d ? i_d_data : i_f_data;
    assign o_m_sel  = grant_d ? i_d_sel  : i_f_sel;

    // ack only to the owner, read data to both
    assign o_d_ack = i_m_ack && grant_d;
    assign o_f_ack = i_m_ack && !grant_d;
    assign o_rdata = i_m_data;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            busy_q  <= 1'b0;
            owner_q <= 1'b1;
        end
        else if (busy_q)
        begin
            // release on ack, master drops cyc next cycle
            if (i_m_ack)
                busy_q <= 1'b0;
        end
        else if (o_m_cyc)
        begin
            busy_q  <= 1'b1;
            owner_q <= grant_d;
        end
    end

    // grant stays put for the whole cycle up to its ack
    property p_grant_stable;
        @(posedge i_clk) disable iff (!i_rst_n)
        (o_m_cyc && !i_m_ack) |=> (grant_d == $past(grant_d));
    endproperty

    a_grant_stable: assert property (p_grant_stable)
        else $error("wb_arbiter: owner changed during an active cycle");

endmodule

// File: hw/fetch_port.sv
`include "mem_subsys_consts.svh"

module fetch_port
    import mem_subsys_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_fetch_req,
    input  logic [`BYTE_AW-1:0]   i_fetch_addr,
    input  logic                  i_wb_ack,
    input  logic [`DATA_W-1:0]    i_wb_data,
    output logic                  o_fetch_busy,
    output logic                  o_fetch_valid,
    output logic [`DATA_W-1:0]    o_fetch_instr,
    output logic                  o_wb_cyc,
    output logic                  o_wb_stb,
    output logic [`MEM_AW-1:0]    o_wb_addr
);

    port_state_e        state_q;
    // word address of the pending fetch
    logic [`MEM_AW-1:0] addr_q;

    assign o_fetch_busy = (state_q != PORT_IDLE);
    // bus request held until ack
    assign o_wb_cyc     = (state_q == PORT_WAIT_ACK);
    assign o_wb_stb     = (state_q == PORT_WAIT_ACK);
    assign o_wb_addr    = addr_q;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            state_q       <= PORT_IDLE;
            o_fetch_valid <= 1'b0;
        end
        else
        begin
            o_fetch_valid <= 1'b0;
            case (state_q)
                PORT_IDLE:
                begin
                    if (i_fetch_req)
                        state_q <= PORT_WAIT_GRANT;
                end
                PORT_WAIT_GRANT:
                    state_q <= PORT_WAIT_ACK;
                PORT_WAIT_ACK:
                begin
                    if (i_wb_ack)
                    begin
                        state_q       <= PORT_IDLE;
                        o_fetch_valid <= 1'b1;
                    end
                end
                default:
                    state_q <= PORT_IDLE;
            endcase
        end
    end

    // payload, low two byte bits dropped
    always_ff @(posedge i_clk)
    begin
        if (state_q == PORT_IDLE && i_fetch_req)
            addr_q <= i_fetch_addr[`BYTE_AW-1:2];
        if (state_q == PORT_WAIT_ACK && i_wb_ack)
            o_fetch_instr <= i_wb_data;
    end

    // one outstanding fetch only
    a_no_req_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_fetch_req |-> state_q == PORT_IDLE)
        else $error("fetch_port: request while busy");

endmodule

// File: hw/lsu_port.sv
`include "mem_subsys_consts.svh"

module lsu_port
    import mem_subsys_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  lsu_op_e               i_lsu_op,
    input  logic                  i_lsu_req,
    input  logic [`BYTE_AW-1:0]   i_lsu_addr,
    input  logic [`DATA_W-1:0]    i_lsu_wdata,
    input  logic                  i_wb_ack,
    input  logic [`DATA_W-1:0]    i_wb_data,
    output logic                  o_lsu_busy,
    output logic                  o_lsu_done,
    output logic [`DATA_W-1:0]    o_lsu_rdata,
    output logic                  o_lsu_misalign,
    output logic                  o_wb_cyc,
    output logic                  o_wb_stb,
    output logic                  o_wb_we,
    output logic [`MEM_AW-1:0]    o_wb_addr,
    output logic [`DATA_W-1:0]    o_wb_data,
    output logic [`DATA_W/8-1:0]  o_wb_sel
);

    port_state_e          state_q;
    // latched request
    lsu_op_e              op_q;
    logic [1:0]           off_q;
    logic                 mis_q;
    // decode of the incoming request
    logic                 req_store;
    logic                 req_half;
    logic                 req_word;
    logic                 req_misalign;
    logic [`DATA_W/8-1:0] req_sel;
    logic [`DATA_W-1:0]   req_wdata;
    // load path
    logic [`DATA_W-1:0]   shifted;
    logic [`DATA_W-1:0]   load_val;

    always_comb
    begin
        req_store = (i_lsu_op == LSU_SB) || (i_lsu_op == LSU_SH) || (i_lsu_op == LSU_SW);
        req_half  = (i_lsu_op == LSU_LH) || (i_lsu_op == LSU_LHU) || (i_lsu_op == LSU_SH);
        req_word  = (i_lsu_op == LSU_LW) || (i_lsu_op == LSU_SW);
        // half needs an even address and word needs bits [1:0] clear
        req_misalign = (req_half && i_lsu_addr[0]) || (req_word && (i_lsu_addr[1:0] != 2'b00));
        // lanes start at the addressed byte
        if (req_word)
        begin
            req_sel   = 4'b1111;
            req_wdata = i_lsu_wdata;
        end
        else if (req_half)
        begin
            req_sel   = 4'b0011 << i_lsu_addr[1:0];
            req_wdata = {2{i_lsu_wdata[15:0]}};
        end
        else
        begin
            req_sel   = 4'b0001 << i_lsu_addr[1:0];
            req_wdata = {4{i_lsu_wdata[7:0]}};
        end
    end

    // addressed lane down to bit 0 and then extended
    assign shifted = i_wb_data >> {off_q, 3'b000};

    always_comb
    begin
        case (op_q)
            LSU_LB:  load_val = {{24{shifted[7]}}, shifted[7:0]};
            LSU_LH:  load_val = {{16{shifted[15]}}, shifted[15:0]};
            LSU_LBU: load_val = {24'd0, shifted[7:0]};
            LSU_LHU: load_val = {16'd0, shifted[15:0]};
            default: load_val = i_wb_data;
        endcase
    end

    assign o_lsu_busy = (state_q != PORT_IDLE);
    assign o_wb_cyc   = (state_q == PORT_WAIT_ACK);
    assign o_wb_stb   = (state_q == PORT_WAIT_ACK);

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            state_q        <= PORT_IDLE;
            o_lsu_done     <= 1'b0;
            o_lsu_misalign <= 1'b0;
        end
        else
        begin
            o_lsu_done     <= 1'b0;
            o_lsu_misalign <= 1'b0;
            case (state_q)
                PORT_IDLE:
                begin
                    if (i_lsu_req)
                        state_q <= PORT_WAIT_GRANT;
                end
                PORT_WAIT_GRANT:
                begin
                    // misaligned never touches the bus
                    if (mis_q)
                    begin
                        state_q        <= PORT_IDLE;
                        o_lsu_done     <= 1'b1;
                        o_lsu_misalign <= 1'b1;
                    end
                    else
                        state_q <= PORT_WAIT_ACK;
                end
                PORT_WAIT_ACK:
                begin
                    if (i_wb_ack)
                    begin
                        state_q    <= PORT_IDLE;
                        o_lsu_done <= 1'b1;
                    end
                end
                default:
                    state_q <= PORT_IDLE;
            endcase
        end
    end

    // payload registers
    always_ff @(posedge i_clk)
    begin
        if (state_q == PORT_IDLE && i_lsu_req)
        begin
            op_q      <= i_lsu_op;
            off_q     <= i_lsu_addr[1:0];
            mis_q     <= req_misalign;
            o_wb_we   <= req_store;
            o_wb_addr <= i_lsu_addr[`BYTE_AW-1:2];
            o_wb_data <= req_wdata;
            o_wb_sel  <= req_sel;
        end
        // only loads update the result
        if (state_q == PORT_WAIT_ACK && i_wb_ack && !o_wb_we)
            o_lsu_rdata <= load_val;
    end

    // one outstanding access only
    a_no_req_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_lsu_req |-> state_q == PORT_IDLE)
        else $error("lsu_port: request while busy");

endmodule

// File: hw/mem_subsys.sv
`include "mem_subsys_consts.svh"

module mem_subsys
    import mem_subsys_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    // instruction fetch
    input  logic                  i_fetch_req,
    input  logic [`BYTE_AW-1:0]   i_fetch_addr,
    output logic                  o_fetch_busy,
    output logic                  o_fetch_valid,
    output logic [`DATA_W-1:0]    o_fetch_instr,
    // load/store
    input  logic                  i_lsu_req,
    input  lsu_op_e               i_lsu_op,
    input  logic [`BYTE_AW-1:0]   i_lsu_addr,
    input  logic [`DATA_W-1:0]    i_lsu_wdata,
    output logic                  o_lsu_busy,
    output logic                  o_lsu_done,
    output logic [`DATA_W-1:0]    o_lsu_rdata,
    output logic                  o_lsu_misalign
);

    // fetch master
    logic                 f_wb_cyc;
    logic                 f_wb_stb;
    logic [`MEM_AW-1:0]   f_wb_addr;
    logic                 f_wb_ack;
    // data master
    logic                 d_wb_cyc;
    logic                 d_wb_stb;
    logic                 d_wb_we;
    logic [`MEM_AW-1:0]   d_wb_addr;
    logic [`DATA_W-1:0]   d_wb_data;
    logic [`DATA_W/8-1:0] d_wb_sel;
    logic                 d_wb_ack;
    // shared read data back to both masters
    logic [`DATA_W-1:0]   wb_rdata;
    // memory side
    logic                 m_wb_cyc;
    logic                 m_wb_stb;
    logic                 m_wb_we;
    logic [`MEM_AW-1:0]   m_wb_addr;
    logic [`DATA_W-1:0]   m_wb_data;
    logic [`DATA_W/8-1:0] m_wb_sel;
    logic                 m_wb_ack;
    logic [`DATA_W-1:0]   m_wb_rdata;

    fetch_port u_fetch
    (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_fetch_req   (i_fetch_req),
        .i_fetch_addr  (i_fetch_addr),
        .i_wb_ack      (f_wb_ack),
        .i_wb_data     (wb_rdata),
        .o_fetch_busy  (o_fetch_busy),
        .o_fetch_valid (o_fetch_valid),
        .o_fetch_instr (o_fetch_instr),
        .o_wb_cyc      (f_wb_cyc),
        .o_wb_stb      (f_wb_stb),
        .o_wb_addr     (f_wb_addr)
    );

    lsu_port u_lsu
    (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_lsu_op       (i_lsu_op),
        .i_lsu_req      (i_lsu_req),
        .i_lsu_addr     (i_lsu_addr),
        .i_lsu_wdata    (i_lsu_wdata),
        .i_wb_ack       (d_wb_ack),
        .i_wb_data      (wb_rdata),
        .o_lsu_busy     (o_lsu_busy),
        .o_lsu_done     (o_lsu_done),
        .o_lsu_rdata    (o_lsu_rdata),
        .o_lsu_misalign (o_lsu_misalign),
        .o_wb_cyc       (d_wb_cyc),
        .o_wb_stb       (d_wb_stb),
        .o_wb_we        (d_wb_we),
        .o_wb_addr      (d_wb_addr),
        .o_wb_data      (d_wb_data),
        .o_wb_sel       (d_wb_sel)
    );

    // fetch is read only, full word
    wb_arbiter u_arb
    (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_f_cyc  (f_wb_cyc),
        .i_f_stb  (f_wb_stb),
        .i_f_we   (1'b0),
        .i_f_addr (f_wb_addr),
        .i_f_data ({`DATA_W{1'b0}}),
        .i_f_sel  (4'b1111),
        .i_d_cyc  (d_wb_cyc),
        .i_d_stb  (d_wb_stb),
        .i_d_we   (d_wb_we),
        .i_d_addr (d_wb_addr),
        .i_d_data (d_wb_data),
        .i_d_sel  (d_wb_sel),
        .i_m_ack  (m_wb_ack),
        .i_m_data (m_wb_rdata),
        .o_f_ack  (f_wb_ack),
        .o_d_ack  (d_wb_ack),
        .o_rdata  (wb_rdata),
        .o_m_cyc  (m_wb_cyc),
        .o_m_stb  (m_wb_stb),
        .o_m_we   (m_wb_we),
        .o_m_addr (m_wb_addr),
        .o_m_data (m_wb_data),
        .o_m_sel  (m_wb_sel)
    );

    // stall is always low, nothing upstream waits on it
    main_memory u_mem
    (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_wb_cyc   (m_wb_cyc),
        .i_wb_stb   (m_wb_stb),
        .i_wb_we    (m_wb_we),
        .i_wb_addr  (m_wb_addr),
        .i_wb_data  (m_wb_data),
        .i_wb_sel   (m_wb_sel),
        .o_wb_ack   (m_wb_ack),
        .o_wb_stall (),
        .o_wb_data  (m_wb_rdata)
    );

endmodule

// File: tests/tb_mem_subsys.sv
`include "mem_subsys_consts.svh"

module tb_mem_subsys
    import mem_subsys_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // trace names up to 24 characters
    localparam int NAME_W      = 8 * 24;
    localparam int HALF_PERIOD = 50;

    logic                  i_clk;
    logic                  i_rst_n;
    // fetch port
    logic                  i_fetch_req;
    logic [`BYTE_AW-1:0]   i_fetch_addr;
    logic                  o_fetch_busy;
    logic                  o_fetch_valid;
    logic [`DATA_W-1:0]    o_fetch_instr;
    // load/store port
    logic                  i_lsu_req;
    lsu_op_e               i_lsu_op;
    logic [`BYTE_AW-1:0]   i_lsu_addr;
    logic [`DATA_W-1:0]    i_lsu_wdata;
    logic                  o_lsu_busy;
    logic                  o_lsu_done;
    logic [`DATA_W-1:0]    o_lsu_rdata;
    logic                  o_lsu_misalign;

    // one entry per trace line
    logic [NAME_W-1:0]     t_name [$];
    logic [7:0]            t_kind [$];
    lsu_op_e               t_op [$];
    logic [`BYTE_AW-1:0]   t_addr [$];
    logic [`DATA_W-1:0]    t_wdata [$];
    logic [`DATA_W-1:0]    t_expect [$];
    logic                  t_mis [$];

    // word image of what the stores should have left in the ram
    logic [`DATA_W-1:0]    ref_mem [`MEM_WORDS];

    int                    n_tests;
    int                    pass_count;
    int                    fail_count;
    logic                  trace_loaded;
    logic                  trace_bad;

    mem_subsys u_dut
    (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_fetch_req    (i_fetch_req),
        .i_fetch_addr   (i_fetch_addr),
        .o_fetch_busy   (o_fetch_busy),
        .o_fetch_valid  (o_fetch_valid),
        .o_fetch_instr  (o_fetch_instr),
        .i_lsu_req      (i_lsu_req),
        .i_lsu_op       (i_lsu_op),
        .i_lsu_addr     (i_lsu_addr),
        .i_lsu_wdata    (i_lsu_wdata),
        .o_lsu_busy     (o_lsu_busy),
        .o_lsu_done     (o_lsu_done),
        .o_lsu_rdata    (o_lsu_rdata),
        .o_lsu_misalign (o_lsu_misalign)
    );

    // 100 ns clock
    initial
    begin
        i_clk = 1'b0;
        forever #HALF_PERIOD i_clk = ~i_clk;
    end

    // hang guard sized from the trace length
    initial
    begin
        wait (trace_loaded);
        repeat (n_tests * 20 + 50) @(posedge i_clk);
        $display("watchdog expired after %0d cycles, a request never completed",
                 n_tests * 20 + 50);
        $display("Regression failed");
        $finish;
    end

    // reads name, kind, op, addr, wdata, expected, misalign per line
    task automatic load_trace();
        int                  fd;
        int                  code;
        int                  ch;
        logic [NAME_W-1:0]   name;
        logic [7:0]          kind;
        logic [23:0]         op_s;
        logic [`BYTE_AW-1:0] addr;
        logic [`DATA_W-1:0]  wdata;
        logic [`DATA_W-1:0]  expect_v;
        logic                mis;
        lsu_op_e             op;

        fd = $fopen("tests/mem_subsys_trace.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open tests/mem_subsys_trace.txt");
            trace_bad = 1'b1;
            return;
        end
        while (!$feof(fd))
        begin
            code = $fscanf(fd, "%s", name);
            if (code != 1)
                break;
            // comment line, skip to newline or end of file
            if (name[7:0] == "#")
            begin
                ch = $fgetc(fd);
                while (ch != 10 && ch != -1)
                    ch = $fgetc(fd);
                continue;
            end
            code = $fscanf(fd, "%s %s %h %h %h %d", kind, op_s, addr, wdata, expect_v, mis);
            if (code != 6)
            begin
                $display("trace line %0s is missing columns", name);
                trace_bad = 1'b1;
                break;
            end
            op = LSU_LW;
            case (op_s)
                {8'd0, "LB"}: op = LSU_LB;
                {8'd0, "LH"}: op = LSU_LH;
                {8'd0, "LW"}: op = LSU_LW;
                "LBU":        op = LSU_LBU;
                "LHU":        op = LSU_LHU;
                {8'd0, "SB"}: op = LSU_SB;
                {8'd0, "SH"}: op = LSU_SH;
                {8'd0, "SW"}: op = LSU_SW;
                default:
                begin
                    $display("trace line %0s has an unknown opcode", name);
                    trace_bad = 1'b1;
                end
            endcase
            t_name.push_back(name);
            t_kind.push_back(kind);
            t_op.push_back(op);
            t_addr.push_back(addr);
            t_wdata.push_back(wdata);
            t_expect.push_back(expect_v);
            t_mis.push_back(mis);
        end
        $fclose(fd);
        n_tests = t_name.size();
    endtask

    // stores replace 1, 2 or 4 bytes from the addressed lane up
    function automatic void update_model(lsu_op_e op, logic [`BYTE_AW-1:0] addr,
                                         logic [`DATA_W-1:0] wdata);
        int nbytes;

        nbytes = (op == LSU_SB) ? 1 : ((op == LSU_SH) ? 2 : 4);
        for (int b = 0; b < nbytes; b++)
            ref_mem[addr[`BYTE_AW-1:2]][8 * (addr[1:0] + b) +: 8] = wdata[8 * b +: 8];
    endfunction

    // sign or zero extension of the addressed lane
    function automatic logic [`DATA_W-1:0] predict_load(lsu_op_e op,
                                                        logic [`BYTE_AW-1:0] addr);
        logic [`DATA_W-1:0] word;
        logic [`DATA_W-1:0] lane;

        word = ref_mem[addr[`BYTE_AW-1:2]];
        lane = word >> (8 * addr[1:0]);
        case (op)
            LSU_LB:  return 32'($signed(lane[7:0]));
            LSU_LH:  return 32'($signed(lane[15:0]));
            LSU_LBU: return 32'(lane[7:0]);
            LSU_LHU: return 32'(lane[15:0]);
            default: return word;
        endcase
    endfunction

    // halves on even bytes, words on word boundaries
    function automatic logic op_misaligned(lsu_op_e op, logic [`BYTE_AW-1:0] addr);
        case (op)
            LSU_LH, LSU_LHU, LSU_SH: return addr[0];
            LSU_LW, LSU_SW:          return addr[1:0] != 2'b00;
            default:                 return 1'b0;
        endcase
    endfunction

    task automatic check_reset();
        logic [4:0] flags;

        flags = {o_fetch_busy, o_fetch_valid, o_lsu_busy, o_lsu_done, o_lsu_misalign};
        if (flags != 5'b00000)
        begin
            $display("FAILED reset_state: expected 00000, actual %05b", flags);
            $display("test reset_state error");
            fail_count++;
        end
        else
        begin
            $display("test reset_state ok");
            pass_count++;
        end
    endtask

    // entered 10 ns after a rising edge
    task automatic run_test(input int idx);
        logic [NAME_W-1:0]   name;
        lsu_op_e             op;
        logic [`BYTE_AW-1:0] addr;
        logic [`DATA_W-1:0]  want;
        logic [`DATA_W-1:0]  model_val;
        logic [`DATA_W-1:0]  lsu_val;
        logic [`DATA_W-1:0]  fetch_val;
        logic                use_lsu;
        logic                use_fetch;
        logic                lsu_seen;
        logic                fetch_seen;
        logic                lsu_mis;
        logic                is_store;
        logic                mis_model;
        logic                ok;
        int                  cycle;
        int                  lsu_cycle;
        int                  fetch_cycle;
        int                  lat;
        int                  exp_lat;

        name      = t_name[idx];
        op        = t_op[idx];
        addr      = t_addr[idx];
        want      = t_expect[idx];
        use_lsu   = (t_kind[idx] != "F");
        use_fetch = (t_kind[idx] != "L");
        is_store  = op inside {LSU_SB, LSU_SH, LSU_SW};
        ok          = 1'b1;
        lsu_seen    = !use_lsu;
        fetch_seen  = !use_fetch;
        lsu_val     = '0;
        fetch_val   = '0;
        lsu_mis     = 1'b0;
        lsu_cycle   = 0;
        fetch_cycle = 0;

        // B lines raise both requests on the same edge
        if (use_lsu)
        begin
            i_lsu_req   = 1'b1;
            i_lsu_op    = op;
            i_lsu_addr  = addr;
            i_lsu_wdata = t_wdata[idx];
        end
        if (use_fetch)
        begin
            i_fetch_req  = 1'b1;
            i_fetch_addr = addr;
        end

        // cycle 0 is the edge that samples the request
        cycle = -1;
        while (!(lsu_seen && fetch_seen))
        begin
            @(posedge i_clk);
            #10;
            i_lsu_req   = 1'b0;
            i_fetch_req = 1'b0;
            cycle++;
            if (!lsu_seen && o_lsu_done)
            begin
                lsu_seen  = 1'b1;
                lsu_cycle = cycle;
                lsu_val   = o_lsu_rdata;
                lsu_mis   = o_lsu_misalign;
            end
            if (!fetch_seen && o_fetch_valid)
            begin
                fetch_seen  = 1'b1;
                fetch_cycle = cycle;
                fetch_val   = o_fetch_instr;
            end
        end

        // model update, data side first on a tie
        mis_model = use_lsu && op_misaligned(op, addr);
        if (mis_model != t_mis[idx])
        begin
            $display("%0s: trace misalign flag disagrees with the alignment rule", name);
            ok = 1'b0;
        end
        if (use_lsu && is_store && !mis_model)
            update_model(op, addr, t_wdata[idx]);
        if (use_fetch)
            model_val = predict_load(LSU_LW, addr);
        else if (!is_store && !mis_model)
            model_val = predict_load(op, addr);
        else
            model_val = want;
        if (model_val != want)
        begin
            $display("%0s: trace value %08h disagrees with the memory model value %08h",
                     name, want, model_val);
            ok = 1'b0;
        end

        // DUT against the trace
        if (use_lsu && lsu_mis != t_mis[idx])
        begin
            $display("FAILED %0s misalign: expected %0d, actual %0d", name, t_mis[idx], lsu_mis);
            ok = 1'b0;
        end
        if (!use_fetch && !is_store && !t_mis[idx] && lsu_val != want)
        begin
            $display("FAILED %0s rdata: expected %08h, actual %08h", name, want, lsu_val);
            ok = 1'b0;
        end
        if (use_fetch && fetch_val != want)
        begin
            $display("FAILED %0s instr: expected %08h, actual %08h", name, want, fetch_val);
            ok = 1'b0;
        end
        if (t_kind[idx] != "B")
        begin
            // 3 cycles on the bus, 1 when rejected as misaligned
            exp_lat = (use_lsu && t_mis[idx]) ? 1 : 3;
            lat     = use_lsu ? lsu_cycle : fetch_cycle;
            if (lat != exp_lat)
            begin
                $display("FAILED %0s latency: expected %0d, actual %0d", name, exp_lat, lat);
                ok = 1'b0;
            end
        end
        else if (lsu_cycle > fetch_cycle)
        begin
            $display("%0s: load/store done came after the fetch result", name);
            ok = 1'b0;
        end

        if (ok)
        begin
            $display("test %0s ok", name);
            pass_count++;
        end
        else
        begin
            $display("test %0s error", name);
            fail_count++;
        end
    endtask

    initial
    begin
        i_rst_n      = 1'b0;
        i_fetch_req  = 1'b0;
        i_fetch_addr = '0;
        i_lsu_req    = 1'b0;
        i_lsu_op     = LSU_LW;
        i_lsu_addr   = '0;
        i_lsu_wdata  = '0;
        n_tests      = 0;
        pass_count   = 0;
        fail_count   = 0;
        trace_bad    = 1'b0;
        trace_loaded = 1'b0;
        load_trace();
        trace_loaded = 1'b1;

        // reset over 8 edges, released off the edge
        repeat (8) @(posedge i_clk);
        #10;
        i_rst_n = 1'b1;
        @(posedge i_clk);
        #10;
        check_reset();

        if (!trace_bad)
        begin
            for (int i = 0; i < n_tests; i++)
                run_test(i);
        end

        $display("%0d tests, %0d passed, %0d failed",
                 pass_count + fail_count, pass_count, fail_count);
        if (fail_count == 0 && !trace_bad && n_tests > 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// File: tests/mem_subsys_trace.txt
# name kind op addr wdata expected misalign, values in hex except misalign
# kind F fetch, L load/store, B store and fetch of one word on the same edge (expected is the fetch word)
sw_w0     L SW  000 11223344 00000000 0
sw_w1     L SW  004 a5a5f00f 00000000 0
sw_top    L SW  3fc deadbeef 00000000 0
f_w0      F LW  000 00000000 11223344 0
f_w1      F LW  004 00000000 a5a5f00f 0
f_w1_b6   F LW  006 00000000 a5a5f00f 0
f_top     F LW  3fc 00000000 deadbeef 0
lw_w0     L LW  000 00000000 11223344 0
lw_w1     L LW  004 00000000 a5a5f00f 0
lw_top    L LW  3fc 00000000 deadbeef 0
sw_m0     L SW  010 cafef00d 00000000 0
sb_m1     L SB  011 000000aa 00000000 0
sh_m2     L SH  012 00001234 00000000 0
sb_m0     L SB  010 ffffff5c 00000000 0
lw_m      L LW  010 00000000 1234aa5c 0
sw_x      L SW  020 807f8000 00000000 0
lb_x0     L LB  020 00000000 00000000 0
lb_x1     L LB  021 00000000 ffffff80 0
lbu_x1    L LBU 021 00000000 00000080 0
lb_x2     L LB  022 00000000 0000007f 0
lbu_x2    L LBU 022 00000000 0000007f 0
lb_x3     L LB  023 00000000 ffffff80 0
lbu_x3    L LBU 023 00000000 00000080 0
lh_x0     L LH  020 00000000 ffff8000 0
lhu_x0    L LHU 020 00000000 00008000 0
lh_x2     L LH  022 00000000 ffff807f 0
lhu_x2    L LHU 022 00000000 0000807f 0
sw_a      L SW  030 600dc0de 00000000 0
lh_a1     L LH  031 00000000 00000000 1
sw_a2     L SW  032 badbadba 00000000 1
sh_a3     L SH  033 0000ffff 00000000 1
lw_a2     L LW  032 00000000 00000000 1
lw_a      L LW  030 00000000 600dc0de 0
sw_c      L SW  040 0f1e2d3c 00000000 0
both_c0   B SW  040 13579bdf 13579bdf 0
both_c1   B SB  041 000000ee 1357eedf 0
lw_c      L LW  040 00000000 1357eedf 0

// File: mem_subsys.f
+incdir+hw
hw/mem_subsys_pkg.sv
hw/main_memory.sv
hw/wb_arbiter.sv
hw/fetch_port.sv
hw/lsu_port.sv
hw/mem_subsys.sv
tests/tb_mem_subsys.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the memory subsystem testbench under verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_mem_subsys \
    -Mdir obj_dir -o sim_mem_subsys \
    -f mem_subsys.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_mem_subsys > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# verdict comes from the log
if grep -q "Regression failed" "$LOG"; then
    exit 1
fi
exit 0
